//--- common/idct_pkg.sv
// Instruction cache tag directory shared way types and tag parity helper
package idct_pkg;

  // Associativity of the tag store
  localparam int NUM_WAYS = 4;
  localparam int WAY_W = $clog2(NUM_WAYS);

  // Widest tag that the parity helper accepts
  localparam int MAX_TAG_W = 64;

  // Way index of a request
  typedef logic [WAY_W-1:0] way_t;

  // One write enable per way, at most one bit set
  typedef logic [NUM_WAYS-1:0] wrway_t;

  // Even parity over a tag
  // Callers zero-extend narrower tags, which leaves the parity unchanged
  function automatic logic tag_parity(input logic [MAX_TAG_W-1:0] tag);
    logic par;
    par = ^tag;
    return par;
  endfunction

endpackage

//--- common/idct_req_if.sv
// Tag request channel with valid/ready flow control between intake, queue and array
interface idct_req_if
  import idct_pkg::*;
#(
  parameter int ADDR_W = 7,
  parameter int TAG_W  = 32
);

  // Handshake
  logic              valid;
  logic              ready;

  // Request fields, data is {parity, tag}
  logic              write;
  logic [ADDR_W-1:0] addr;
  way_t              way;
  logic [TAG_W:0]    data;

  // Sender of a request
  modport src (
    output valid, write, addr, way, data,
    input  ready
  );

  // Receiver of a request
  modport dst (
    input  valid, write, addr, way, data,
    output ready
  );

endinterface

//--- logic/req_intake.sv
// Request intake that acts as a four-phase req/ack slave and pushes parity-protected requests
module req_intake
  import idct_pkg::*;
#(
  parameter int ADDR_W = 7,
  parameter int TAG_W  = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  logic              write,
  input  logic [ADDR_W-1:0] addr,
  input  way_t              way,
  input  logic [TAG_W-1:0]  tag,
  input  logic              err_inject,
  output logic              ack,
  idct_req_if.src           push
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PUSH,
    ST_ACKED,
    ST_RELEASE
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   parity;

  // Stored parity, inverted on request to plant a parity error
  assign parity = tag_parity(MAX_TAG_W'(tag)) ^ err_inject;

  // Requester holds the fields stable while req is high
  assign push.write = write;
  assign push.addr  = addr;
  assign push.way   = way;
  assign push.data  = {parity, tag};

  always_comb begin
    state_nxt  = state;
    push.valid = 1'b0;
    case (state)
      ST_IDLE: begin
        // Offer the request in the first cycle req is seen
        push.valid = req;
        if (req && push.ready) begin
          state_nxt = ST_ACKED;
        end else if (req) begin
          state_nxt = ST_PUSH;
        end
      end
      ST_PUSH: begin
        // Queue full, keep offering until it accepts
        push.valid = 1'b1;
        if (push.ready) begin
          state_nxt = ST_ACKED;
        end
      end
      ST_ACKED: begin
        if (!req) begin
          state_nxt = ST_RELEASE;
        end
      end
      ST_RELEASE: begin
        state_nxt = ST_IDLE;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ack comes straight from the state register, high the cycle after the push
  assign ack = (state == ST_ACKED);

endmodule

//--- logic/req_fifo.sv
// In-order request queue with valid/ready on both sides
module req_fifo
  import idct_pkg::*;
#(
  parameter int ADDR_W     = 7,
  parameter int TAG_W      = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic    clk,
  input  logic    reset,
  idct_req_if.dst in,
  idct_req_if.src out
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Entry storage
  logic              write_q [FIFO_DEPTH];
  logic [ADDR_W-1:0] addr_q  [FIFO_DEPTH];
  way_t              way_q   [FIFO_DEPTH];
  logic [TAG_W:0]    data_q  [FIFO_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign in.ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out.valid = (count != '0);

  assign do_push = in.valid && in.ready;
  assign do_pop  = out.valid && out.ready;

  // Head entry is presented directly
  assign out.write = write_q[rd_ptr];
  assign out.addr  = addr_q[rd_ptr];
  assign out.way   = way_q[rd_ptr];
  assign out.data  = data_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      write_q[wr_ptr] <= in.write;
      addr_q[wr_ptr]  <= in.addr;
      way_q[wr_ptr]   <= in.way;
      data_q[wr_ptr]  <= in.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- idct_array/idct_array.sv
// Tag store with per-entry written bits, one-hot way writes and a registered single-way read
module idct_array
  import idct_pkg::*;
#(
  parameter int ADDR_W = 7,
  parameter int TAG_W  = 32
) (
  input  logic           clk,
  input  logic           reset,
  idct_req_if.dst        req,
  output logic           rd_valid,
  output logic [TAG_W:0] rd_data,
  output logic           rd_written
);

  localparam int NUM_SETS = 1 << ADDR_W;

  // Tag words per way and set, {parity, tag}
  logic [TAG_W:0]      tag_mem [NUM_WAYS][NUM_SETS];

  // Written flags, one bit per way in each set
  logic [NUM_WAYS-1:0] written [NUM_SETS];

  wrway_t              wrway;
  logic                rd_en;

  // The array takes one request every cycle
  assign req.ready = 1'b1;

  // Way decode into write enables
  assign wrway = (req.valid && req.write) ? (wrway_t'(1) << req.way) : '0;
  assign rd_en = req.valid && !req.write;

  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wrway[w]) begin
        tag_mem[w][req.addr] <= req.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        written[s] <= '0;
      end
    end else begin
      written[req.addr] <= written[req.addr] | wrway;
    end
  end

  // Read result holds its value on write and idle cycles
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data    <= tag_mem[req.way][req.addr];
      rd_written <= written[req.addr][req.way];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

//--- logic/read_resp.sv
// Read response stage that registers results and checks stored parity
module read_resp
  import idct_pkg::*;
#(
  parameter int TAG_W = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             rd_valid,
  input  logic [TAG_W:0]   rd_data,
  input  logic             rd_written,
  output logic             resp_valid,
  output logic [TAG_W-1:0] resp_tag,
  output logic             resp_written,
  output logic             resp_parity_err
);

  logic [TAG_W-1:0] rd_tag;
  logic             rd_parity;
  logic             parity_bad;

  // Word layout is {parity, tag}
  assign rd_tag    = rd_data[TAG_W-1:0];
  assign rd_parity = rd_data[TAG_W];

  // Never-written entries hold no meaningful parity
  assign parity_bad = rd_written && (tag_parity(MAX_TAG_W'(rd_tag)) != rd_parity);

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      resp_tag        <= rd_tag;
      resp_written    <= rd_written;
      resp_parity_err <= parity_bad;
    end
  end

  // One pulse per read
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rd_valid;
    end
  end

endmodule

//--- logic/icache_tag_dir.sv
// Instruction cache tag directory top with four-phase request port and read responses
module icache_tag_dir
  import idct_pkg::*;
#(
  parameter int ADDR_W     = 7,
  parameter int TAG_W      = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  logic              req_write,
  input  logic [ADDR_W-1:0] req_addr,
  input  way_t              req_way,
  input  logic [TAG_W-1:0]  req_tag,
  input  logic              req_err_inject,
  output logic              ack,
  output logic              resp_valid,
  output logic [TAG_W-1:0]  resp_tag,
  output logic              resp_written,
  output logic              resp_parity_err
);

  idct_req_if #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) intake_to_fifo ();
  idct_req_if #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) fifo_to_array ();

  logic           rd_valid;
  logic [TAG_W:0] rd_data;
  logic           rd_written;

  req_intake #(
    .ADDR_W (ADDR_W),
    .TAG_W  (TAG_W)
  ) u_intake (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .write      (req_write),
    .addr       (req_addr),
    .way        (req_way),
    .tag        (req_tag),
    .err_inject (req_err_inject),
    .ack        (ack),
    .push       (intake_to_fifo.src)
  );

  req_fifo #(
    .ADDR_W     (ADDR_W),
    .TAG_W      (TAG_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk   (clk),
    .reset (reset),
    .in    (intake_to_fifo.dst),
    .out   (fifo_to_array.src)
  );

  idct_array #(
    .ADDR_W (ADDR_W),
    .TAG_W  (TAG_W)
  ) u_array (
    .clk        (clk),
    .reset      (reset),
    .req        (fifo_to_array.dst),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .rd_written (rd_written)
  );

  read_resp #(
    .TAG_W (TAG_W)
  ) u_resp (
    .clk             (clk),
    .reset           (reset),
    .rd_valid        (rd_valid),
    .rd_data         (rd_data),
    .rd_written      (rd_written),
    .resp_valid      (resp_valid),
    .resp_tag        (resp_tag),
    .resp_written    (resp_written),
    .resp_parity_err (resp_parity_err)
  );

endmodule

//--- dv/clk_gen.sv
// Testbench clock and reset source with an 8 ns clock and a five-cycle reset
module clk_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Synchronous reset released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- dv/tb_icache_tag_dir.sv
// Random-stimulus testbench for the tag directory with a reference model of the tag store
module tb_icache_tag_dir
  import idct_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W = 7;
  localparam int TAG_W = 32;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_SETS = 1 << ADDR_W;
  localparam int PAIR_LEN = 24;
  localparam int BURST_LEN = 200;
  // Reset reads, write/read pairs, overwrite test, parity test, burst
  localparam int TOTAL_REQS = 8 + 2 * PAIR_LEN + 9 + 4 + BURST_LEN;
  localparam int MAX_CYCLES = 40 * TOTAL_REQS;
  localparam int DRAIN_LIMIT = 40;

  logic              clk;
  logic              reset;
  logic              req;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  way_t              req_way;
  logic [TAG_W-1:0]  req_tag;
  logic              req_err_inject;
  logic              ack;
  logic              resp_valid;
  logic [TAG_W-1:0]  resp_tag;
  logic              resp_written;
  logic              resp_parity_err;

  // Reference model of the tag store
  logic [TAG_W-1:0]  model_tag     [NUM_WAYS][NUM_SETS];
  logic              model_written [NUM_WAYS][NUM_SETS];
  logic              model_bad     [NUM_WAYS][NUM_SETS];

  // Expected read responses in request order
  logic [TAG_W-1:0]  exp_tag [$];
  logic              exp_written [$];
  logic              exp_perr [$];

  logic [31:0]       rng_state;
  int                errors = 0;
  int                reads_issued = 0;
  int                resps_seen = 0;
  int                cycle_count = 0;
  logic              ack_prev;
  logic              req_prev;

  clk_gen u_clk (
    .clk   (clk),
    .reset (reset)
  );

  icache_tag_dir #(
    .ADDR_W     (ADDR_W),
    .TAG_W      (TAG_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .req_write       (req_write),
    .req_addr        (req_addr),
    .req_way         (req_way),
    .req_tag         (req_tag),
    .req_err_inject  (req_err_inject),
    .ack             (ack),
    .resp_valid      (resp_valid),
    .resp_tag        (resp_tag),
    .resp_written    (resp_written),
    .resp_parity_err (resp_parity_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %0h, expected %0h", name, actual, expected);
      errors++;
    end
  endtask

  // Four-phase requester, called right after a rising edge with ack low
  task automatic issue_request(input logic write, input logic [ADDR_W-1:0] addr,
                               input way_t way, input logic [TAG_W-1:0] tag, input logic err);
    req            <= 1'b1;
    req_write      <= write;
    req_addr       <= addr;
    req_way        <= way;
    req_tag        <= tag;
    req_err_inject <= err;
    @(posedge clk);
    while (!ack) @(posedge clk);
    // Model follows acceptance order, which is also the array order
    if (write) begin
      model_tag[way][addr]     = tag;
      model_written[way][addr] = 1'b1;
      model_bad[way][addr]     = err;
    end else begin
      exp_tag.push_back(model_tag[way][addr]);
      exp_written.push_back(model_written[way][addr]);
      exp_perr.push_back(model_written[way][addr] && model_bad[way][addr]);
      reads_issued++;
    end
    req <= 1'b0;
    @(posedge clk);
    while (ack) @(posedge clk);
  endtask

  task automatic finish_test(input int num, input string name, input int errors_before);
    int waited;
    waited = 0;
    while (exp_written.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_written.size() != 0) begin
      $display("Missing %0d read responses at the end of test %0d", exp_written.size(), num);
      errors++;
    end
    $display("Test %0d %s: %0d errors", num, name, errors - errors_before);
  endtask

  // ack may only rise after req was high at the previous edge
  initial begin
    ack_prev = 1'b0;
    req_prev = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && ack && !ack_prev && !req_prev) begin
        $display("Protocol error: ack rose while req was low");
        errors++;
      end
      ack_prev = ack;
      req_prev = req;
    end
  end

  initial begin
    logic [TAG_W-1:0] t;
    logic             w;
    logic             p;
    forever begin
      @(posedge clk);
      if (!reset && resp_valid) begin
        resps_seen++;
        if (exp_written.size() == 0) begin
          $display("Unexpected read response with no read outstanding");
          errors++;
        end else begin
          t = exp_tag.pop_front();
          w = exp_written.pop_front();
          p = exp_perr.pop_front();
          check_value("resp_written", 64'(resp_written), 64'(w));
          // Never-written entries hold no defined tag
          if (w) check_value("resp_tag", 64'(resp_tag), 64'(t));
          check_value("resp_parity_err", 64'(resp_parity_err), 64'(p));
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
      end
    end
  end

  initial begin
    int                e;
    logic [31:0]       r;
    logic [ADDR_W-1:0] a;
    way_t              w;
    rng_state      = 32'd9314;
    req            = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_way        = '0;
    req_tag        = '0;
    req_err_inject = 1'b0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        model_tag[i][s]     = '0;
        model_written[i][s] = 1'b0;
        model_bad[i][s]     = 1'b0;
      end
    end
    wait (!reset);
    @(posedge clk);

    e = errors;
    check_value("ack", 64'(ack), 64'(0));
    check_value("resp_valid", 64'(resp_valid), 64'(0));
    for (int i = 0; i < NUM_WAYS; i++) begin
      issue_request(1'b0, '0, way_t'(i), '0, 1'b0);
      issue_request(1'b0, '1, way_t'(i), '0, 1'b0);
    end
    finish_test(1, "reset state", e);

    e = errors;
    for (int i = 0; i < PAIR_LEN; i++) begin
      r = next_rand();
      a = r[ADDR_W-1:0];
      w = way_t'(r[ADDR_W+1:ADDR_W]);
      if (i == 0) a = '0;
      if (i == 1) a = '1;
      issue_request(1'b1, a, w, next_rand(), 1'b0);
      issue_request(1'b0, a, w, '0, 1'b0);
    end
    finish_test(2, "write then read", e);

    e = errors;
    r = next_rand();
    a = r[ADDR_W-1:0];
    w = way_t'(r[ADDR_W+1:ADDR_W]);
    issue_request(1'b1, a, w, next_rand(), 1'b0);
    issue_request(1'b1, a, w, next_rand(), 1'b0);
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (way_t'(i) != w) issue_request(1'b1, a, way_t'(i), next_rand(), 1'b0);
    end
    for (int i = 0; i < NUM_WAYS; i++) begin
      issue_request(1'b0, a, way_t'(i), '0, 1'b0);
    end
    finish_test(3, "last write wins", e);

    e = errors;
    r = next_rand();
    a = r[ADDR_W-1:0];
    w = way_t'(r[ADDR_W+1:ADDR_W]);
    issue_request(1'b1, a, w, next_rand(), 1'b1);
    issue_request(1'b0, a, w, '0, 1'b0);
    issue_request(1'b1, a, w, next_rand(), 1'b0);
    issue_request(1'b0, a, w, '0, 1'b0);
    finish_test(4, "parity", e);

    // Small set range so reads mostly land on written entries
    e = errors;
    for (int i = 0; i < BURST_LEN; i++) begin
      r = next_rand();
      issue_request(r[0], ADDR_W'(r[4:1]), way_t'(r[6:5]), next_rand(),
                    r[0] && (r[9:7] == 3'd0));
    end
    finish_test(5, "burst order", e);
    check_value("response count", 64'(resps_seen), 64'(reads_issued));

    $display("Summary: 5 tests, %0d reads, %0d responses, %0d errors",
             reads_issued, resps_seen, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- project.f
common/idct_pkg.sv
common/idct_req_if.sv
logic/req_intake.sv
logic/req_fifo.sv
idct_array/idct_array.sv
logic/read_resp.sv
logic/icache_tag_dir.sv
dv/clk_gen.sv
dv/tb_icache_tag_dir.sv

//--- Makefile
# Verilator flow for the instruction cache tag directory

TB_TOP  = tb_icache_tag_dir
RTL_TOP = icache_tag_dir
LOG     = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f project.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f project.f \
		--top-module $(TB_TOP) -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
